/* Bender.yml */
package:
  name: rv_cache

export_include_dirs:
  - design

sources:
  - files:
      - design/cache_pkg.sv
      - design/cache_array.sv
      - design/bus_wait_timer.sv
      - design/cache_ctrl_fsm.sv
      - design/rv_cache_top.sv
  - target: test
    files:
      - verification/tb_bus_memory.sv
      - verification/rv_cache_tb.sv

/* design/bus_wait_timer.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module bus_wait_timer
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_run,
    output logic       o_expired,
    output logic [7:0] o_count
);

    localparam logic [7:0] TIMEOUT_CNT = 8'(`CACHE_BUS_TIMEOUT);

    logic [7:0] count_q;

    // ########################################
    // Wait counter
    // ########################################

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            count_q <= '0;
        end
        else if (!i_run)
        begin
            count_q <= '0;                  // Each bus access starts from zero
        end
        else if (count_q != 8'hff)
        begin
            count_q <= count_q + 8'd1;      // Saturates so expiry holds
        end
    end

    assign o_count   = count_q;
    assign o_expired = (count_q >= TIMEOUT_CNT);

endmodule

/* design/cache_array.sv */
`timescale 1ns/1ps

module cache_array
    import cache_pkg::*;
#(
    parameter type entry_t    = word_t,
    parameter int  DEPTH_BITS = 3
)
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [DEPTH_BITS-1:0] i_index,
    input  logic                  i_we,
    input  strb_t                 i_lane_we,
    input  entry_t                i_wdata,
    output entry_t                o_rdata
);

    localparam int DEPTH = 2 ** DEPTH_BITS;
    localparam int W     = $bits(entry_t);

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] bit_mask;
    logic [W-1:0] wdata_bits;
    logic [W-1:0] rdata_q;

    assign wdata_bits = i_wdata;

    // Byte lanes map onto bits 8 at a time and any bits above lane 3 follow lane 3
    always_comb
    begin
        for (int b = 0; b < W; b++)
        begin
            bit_mask[b] = i_lane_we[(b / 8 > 3) ? 3 : b / 8];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_index] <= (mem[i_index] & ~bit_mask) | (wdata_bits & bit_mask);
        end
    end

    // Registered read that returns the old contents on a same-cycle write
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            rdata_q <= '0;
        end
        else
        begin
            rdata_q <= mem[i_index];
        end
    end

    assign o_rdata = entry_t'(rdata_q);

endmodule

/* design/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ########################################
// Cache geometry
// ########################################

// Set index width of the 2**CACHE_SET_BITS one-word lines
`define CACHE_SET_BITS 3

// Byte address width on both the core and the bus side
`define CACHE_ADDR_W 32

// ########################################
// Bus timing
// ########################################

// Cycles spent in bus wait before the access ends with an error
`define CACHE_BUS_TIMEOUT 16

`endif

/* design/cache_ctrl_fsm.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_ctrl_fsm
    import cache_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  cache_req_t                 i_req,
    input  logic                       i_flush,
    input  tag_entry_t                 i_tag_rd,
    input  word_t                      i_data_rd,
    input  logic                       i_bus_ack,
    input  word_t                      i_bus_data,
    input  logic                       i_timeout,
    output logic [`CACHE_SET_BITS-1:0] o_index,
    output logic                       o_tag_we,
    output tag_entry_t                 o_tag_wdata,
    output logic                       o_data_we,
    output strb_t                      o_data_lanes,
    output word_t                      o_data_wdata,
    output bus_req_t                   o_bus,
    output logic                       o_wait,
    output logic                       o_ack,
    output cache_rsp_t                 o_rsp,
    output logic                       o_busy
);

    localparam int SET_W = `CACHE_SET_BITS;

    ctrl_state_t      state_q;
    cache_req_t       req_q;
    cache_rsp_t       rsp_q;
    bus_req_t         bus_q;
    logic [SET_W-1:0] flush_idx_q;
    logic             tag_ready_q;      // Array output belongs to req_q
    logic             hit_q;

    logic [SET_W-1:0] req_index;
    logic [TAG_W-1:0] req_tag;
    logic             lookup_hit;
    logic             req_pending;
    logic             bus_done;

    assign req_index   = req_q.addr[SET_W+1:2];
    assign req_tag     = req_q.addr[`CACHE_ADDR_W-1 -: TAG_W];
    assign lookup_hit  = i_tag_rd.valid && (i_tag_rd.tag == req_tag);
    assign req_pending = i_req.read || i_req.write;
    assign bus_done    = (state_q == BUS_WAIT) && i_bus_ack;

    // ########################################
    // State sequencing
    // ########################################

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state_q     <= FLUSH;   // Invalidate all lines out of reset
            flush_idx_q <= '0;
            tag_ready_q <= 1'b0;
            bus_q       <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    tag_ready_q <= 1'b0;
                    if (req_pending)
                    begin
                        state_q <= LOOKUP;
                    end
                    else if (i_flush)
                    begin
                        state_q     <= FLUSH;
                        flush_idx_q <= '0;
                    end
                end
                LOOKUP:
                begin
                    if (!tag_ready_q)
                    begin
                        tag_ready_q <= 1'b1;
                    end
                    else if (req_q.read && lookup_hit)
                    begin
                        state_q <= RESPOND;
                    end
                    else
                    begin
                        state_q     <= BUS_WAIT;
                        bus_q.addr  <= req_q.addr;
                        bus_q.read  <= req_q.read;
                        bus_q.write <= req_q.write;
                        bus_q.sel   <= req_q.read ? 4'hf : req_q.sel;   // Fills take the whole word
                        bus_q.wdata <= req_q.wdata;
                    end
                end
                BUS_WAIT:
                begin
                    if (i_bus_ack || i_timeout)
                    begin
                        state_q     <= RESPOND;
                        bus_q.read  <= 1'b0;
                        bus_q.write <= 1'b0;
                    end
                end
                RESPOND:
                begin
                    state_q <= IDLE;
                end
                FLUSH:
                begin
                    flush_idx_q <= flush_idx_q + 1'b1;
                    if (flush_idx_q == '1)
                    begin
                        state_q <= IDLE;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // ########################################
    // Request and response capture
    // ########################################

    always_ff @(posedge i_clk)
    begin
        case (state_q)
            IDLE:
            begin
                req_q <= i_req;
            end
            LOOKUP:
            begin
                hit_q      <= lookup_hit;
                rsp_q.data <= i_data_rd;
                rsp_q.miss <= 1'b0;
                rsp_q.err  <= 1'b0;
            end
            BUS_WAIT:
            begin
                rsp_q.miss <= req_q.read || !hit_q;
                rsp_q.data <= (i_bus_ack && req_q.read) ? i_bus_data : '0;
                rsp_q.err  <= !i_bus_ack;   // Only reaches RESPOND on ack or timeout
            end
            default:
            begin
                rsp_q <= rsp_q;
            end
        endcase
    end

    // Fill on read ack, merge the selected bytes on a write hit
    assign o_index      = (state_q == FLUSH) ? flush_idx_q : req_index;
    assign o_tag_we     = (state_q == FLUSH) || (bus_done && req_q.read);
    assign o_tag_wdata  = (state_q == FLUSH) ? tag_entry_t'('0)
                                             : tag_entry_t'{valid: 1'b1, tag: req_tag};
    assign o_data_we    = bus_done && (req_q.read || hit_q);
    assign o_data_lanes = req_q.read ? 4'hf : req_q.sel;
    assign o_data_wdata = req_q.read ? i_bus_data : req_q.wdata;

    assign o_bus  = bus_q;
    assign o_wait = (state_q == BUS_WAIT);
    assign o_ack  = (state_q == RESPOND);
    assign o_rsp  = rsp_q;
    assign o_busy = (state_q == FLUSH);

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

`include "cache_config.svh"

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // Address splits into tag, set index and a 2-bit byte offset
    localparam int TAG_W = `CACHE_ADDR_W - 2 - `CACHE_SET_BITS;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic                     read;
        logic                     write;
        strb_t                    sel;
        word_t                    wdata;
    } cache_req_t;

    typedef struct packed {
        word_t data;
        logic  miss;
        logic  err;                         // Bus timed out
    } cache_rsp_t;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic                     read;
        logic                     write;
        strb_t                    sel;
        word_t                    wdata;
    } bus_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, BUS_WAIT, RESPOND, FLUSH} ctrl_state_t;

endpackage

/* design/rv_cache_top.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module rv_cache_top
    import cache_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  cache_req_t i_req,
    input  logic       i_flush,
    input  logic       i_bus_ack,
    input  word_t      i_bus_data,
    output bus_req_t   o_bus,
    output logic       o_ack,
    output cache_rsp_t o_rsp,
    output logic       o_busy
);

    logic [`CACHE_SET_BITS-1:0] index;
    logic                       tag_we;
    tag_entry_t                 tag_wdata;
    tag_entry_t                 tag_rd;
    logic                       data_we;
    strb_t                      data_lanes;
    word_t                      data_wdata;
    word_t                      data_rd;
    logic                       bus_wait;
    logic                       timeout;

    // ########################################
    // Control
    // ########################################

    cache_ctrl_fsm ctrl_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_req),
        .i_flush      (i_flush),
        .i_tag_rd     (tag_rd),
        .i_data_rd    (data_rd),
        .i_bus_ack    (i_bus_ack),
        .i_bus_data   (i_bus_data),
        .i_timeout    (timeout),
        .o_index      (index),
        .o_tag_we     (tag_we),
        .o_tag_wdata  (tag_wdata),
        .o_data_we    (data_we),
        .o_data_lanes (data_lanes),
        .o_data_wdata (data_wdata),
        .o_bus        (o_bus),
        .o_wait       (bus_wait),
        .o_ack        (o_ack),
        .o_rsp        (o_rsp),
        .o_busy       (o_busy)
    );

    bus_wait_timer timer_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_run     (bus_wait),
        .o_expired (timeout),
        .o_count   ()
    );

    // ########################################
    // Storage
    // ########################################

    cache_array #(
        .entry_t    (tag_entry_t),
        .DEPTH_BITS (`CACHE_SET_BITS)
    ) tag_array_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_index   (index),
        .i_we      (tag_we),
        .i_lane_we (4'hf),                  // Tags are always written whole
        .i_wdata   (tag_wdata),
        .o_rdata   (tag_rd)
    );

    cache_array #(
        .entry_t    (word_t),
        .DEPTH_BITS (`CACHE_SET_BITS)
    ) data_array_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_index   (index),
        .i_we      (data_we),
        .i_lane_we (data_lanes),
        .i_wdata   (data_wdata),
        .o_rdata   (data_rd)
    );

endmodule

/* rv_cache.f */
+incdir+design
design/cache_pkg.sv
design/cache_array.sv
design/bus_wait_timer.sv
design/cache_ctrl_fsm.sv
design/rv_cache_top.sv
verification/tb_bus_memory.sv
verification/rv_cache_tb.sv

/* verification/rv_cache_tb.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module rv_cache_tb
    import cache_pkg::*;
();

    localparam int MEM_BITS        = 10;
    localparam int NSETS           = 1 << `CACHE_SET_BITS;
    localparam int WATCHDOG_CYCLES = 4000;
    localparam logic [31:0] TAG_FLIP = 32'h1 << (`CACHE_SET_BITS + 2);  // Lowest tag bit

    logic       clk;
    logic       rst;
    logic       flush;
    logic       bus_ack;
    logic       ack;
    logic       busy;
    logic       mem_no_ack;
    logic [7:0] mem_latency;
    cache_req_t req;
    cache_rsp_t rsp;
    bus_req_t   bus;
    word_t      bus_data;

    word_t      ref_mem [2 ** MEM_BITS];
    tag_entry_t shadow [NSETS];
    int         error_count = 0;
    int         cycle_count = 0;

    rv_cache_top dut_i (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_req      (req),
        .i_flush    (flush),
        .i_bus_ack  (bus_ack),
        .i_bus_data (bus_data),
        .o_bus      (bus),
        .o_ack      (ack),
        .o_rsp      (rsp),
        .o_busy     (busy)
    );

    tb_bus_memory #(.WORD_BITS(MEM_BITS)) mem_i (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_bus      (bus),
        .i_latency  (mem_latency),
        .i_no_ack   (mem_no_ack),
        .o_bus_ack  (bus_ack),
        .o_bus_data (bus_data)
    );

    always
    begin
        #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= WATCHDOG_CYCLES)
        begin
            $display("Watchdog expired after %0d cycles, a test did not finish", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ########################################
    // Reference model
    // ########################################

    function automatic logic [`CACHE_SET_BITS-1:0] set_of(input logic [31:0] addr);
        return addr[`CACHE_SET_BITS+1:2];
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input logic [31:0] addr);
        return addr[`CACHE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic bit predict_hit(input logic [31:0] addr);
        tag_entry_t e;
        e = shadow[set_of(addr)];
        return e.valid && (e.tag == tag_of(addr));
    endfunction

    function automatic logic [31:0] random_addr(input int unsigned span_words);
        return ($urandom % span_words) << 2;
    endfunction

    // ########################################
    // Compare tasks
    // ########################################

    task automatic check_rsp(input cache_rsp_t got, input cache_rsp_t exp,
                             input bit with_data, input string what);
        if ((with_data && got.data !== exp.data) || got.miss !== exp.miss
            || got.err !== exp.err)
        begin
            error_count++;
            $display("[ERROR] %0t %s: got data %h miss %b err %b, expected data %h miss %b err %b",
                     $time, what, got.data, got.miss, got.err, exp.data, exp.miss, exp.err);
        end
    endtask

    task automatic check_bus(input bus_req_t got, input bus_req_t exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t %s: got addr %h r %b w %b sel %h wdata %h",
                     $time, what, got.addr, got.read, got.write, got.sel, got.wdata);
            $display("[ERROR] %0t %s: expected addr %h r %b w %b sel %h wdata %h",
                     $time, what, exp.addr, exp.read, exp.write, exp.sel, exp.wdata);
        end
    endtask

    // ########################################
    // Access helpers
    // ########################################

    task automatic access_cache(input cache_req_t r, output cache_rsp_t got,
                                output bit saw_bus, output int cycles);
        bus_req_t exp_bus;
        exp_bus.addr  = r.addr;
        exp_bus.read  = 1'b0;
        exp_bus.write = 1'b1;
        exp_bus.sel   = r.sel;
        exp_bus.wdata = r.wdata;
        saw_bus = 1'b0;
        cycles  = 0;
        @(posedge clk);
        #1 req = r;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
            if ((bus.read || bus.write) && !saw_bus)
            begin
                saw_bus = 1'b1;
                if (r.write)
                begin
                    check_bus(bus, exp_bus, "write request on bus");
                end
            end
        end
        while (!ack);
        got = rsp;
        req = '0;                           // Core lets go of the request after the ack
    endtask

    task automatic read_and_compare(input logic [31:0] addr, input string what);
        cache_req_t r;
        cache_rsp_t got;
        cache_rsp_t exp;
        bit         saw_bus;
        int         cycles;
        r        = '0;
        r.addr   = addr;
        r.read   = 1'b1;
        exp.data = ref_mem[addr[MEM_BITS+1:2]];
        exp.miss = !predict_hit(addr);
        exp.err  = 1'b0;
        access_cache(r, got, saw_bus, cycles);
        check_rsp(got, exp, 1'b1, what);
        if (saw_bus !== exp.miss)
        begin
            error_count++;
            $display("[ERROR] %0t %s: bus activity %b, expected %b",
                     $time, what, saw_bus, exp.miss);
        end
        if (!exp.miss && cycles != 3)
        begin
            error_count++;
            $display("[ERROR] %0t %s: hit acked after %0d cycles, expected 3",
                     $time, what, cycles);
        end
        shadow[set_of(addr)].valid = 1'b1;  // A read always leaves the line filled
        shadow[set_of(addr)].tag   = tag_of(addr);
    endtask

    task automatic write_and_compare(input logic [31:0] addr, input strb_t sel,
                                     input word_t data, input string what);
        cache_req_t r;
        cache_rsp_t got;
        cache_rsp_t exp;
        bit         saw_bus;
        int         cycles;
        r        = '0;
        r.addr   = addr;
        r.write  = 1'b1;
        r.sel    = sel;
        r.wdata  = data;
        exp      = '0;
        exp.miss = !predict_hit(addr);
        for (int l = 0; l < 4; l++)
        begin
            if (sel[l])
            begin
                ref_mem[addr[MEM_BITS+1:2]][8*l +: 8] = data[8*l +: 8];
            end
        end
        access_cache(r, got, saw_bus, cycles);
        check_rsp(got, exp, 1'b0, what);
        if (!saw_bus)
        begin
            error_count++;
            $display("[ERROR] %0t %s: write never reached the bus", $time, what);
        end
    endtask

    task automatic flush_cache();
        int busy_cycles;
        busy_cycles = 0;
        @(posedge clk);
        #1 flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        while (busy)
        begin
            busy_cycles++;
            @(posedge clk);
            #1;
        end
        if (busy_cycles != NSETS)
        begin
            error_count++;
            $display("[ERROR] %0t flush kept o_busy high for %0d cycles, expected %0d",
                     $time, busy_cycles, NSETS);
        end
        for (int s = 0; s < NSETS; s++)
        begin
            shadow[s].valid = 1'b0;
        end
    endtask

    // ########################################
    // Directed tests
    // ########################################

    task automatic miss_then_hit();
        logic [31:0] a;
        a = random_addr(2 ** MEM_BITS);
        read_and_compare(a, "first read");
        read_and_compare(a, "repeated read");
    endtask

    task automatic conflict_eviction();
        logic [31:0] a;
        a = random_addr(2 ** MEM_BITS);
        repeat (3)
        begin
            read_and_compare(a, "conflict read a");
            read_and_compare(a ^ TAG_FLIP, "conflict read b");
        end
    endtask

    task automatic write_through();
        logic [31:0] a;
        a = random_addr(2 ** MEM_BITS);
        read_and_compare(a, "read before write");
        write_and_compare(a, strb_t'(($urandom % 15) + 1), $urandom, "write hit");
        read_and_compare(a, "read after write hit");
        write_and_compare(a ^ TAG_FLIP, strb_t'(($urandom % 15) + 1), $urandom, "write miss");
        read_and_compare(a ^ TAG_FLIP, "read after write miss");
    endtask

    task automatic flush_invalidates();
        logic [31:0] a;
        a = random_addr(2 ** MEM_BITS);
        read_and_compare(a, "fill before flush");
        read_and_compare(a + 32'h4, "fill neighbour before flush");
        flush_cache();
        read_and_compare(a, "read after flush");
        read_and_compare(a + 32'h4, "neighbour after flush");
    endtask

    task automatic bus_timeout();
        logic [31:0] a;
        cache_req_t  r;
        cache_rsp_t  got;
        cache_rsp_t  exp;
        bit          saw_bus;
        int          cycles;
        a = random_addr(2 ** MEM_BITS);
        read_and_compare(a, "read before timeout");
        r          = '0;
        r.addr     = a ^ TAG_FLIP;
        r.read     = 1'b1;
        exp        = '0;
        exp.miss   = 1'b1;
        exp.err    = 1'b1;
        mem_no_ack = 1'b1;
        access_cache(r, got, saw_bus, cycles);
        mem_no_ack = 1'b0;
        check_rsp(got, exp, 1'b0, "timed out read");
        if (!saw_bus)
        begin
            error_count++;
            $display("[ERROR] %0t timed out read never reached the bus", $time);
        end
        read_and_compare(a ^ TAG_FLIP, "read after timeout");
    endtask

    task automatic random_latency_reads();
        repeat (40)
        begin
            mem_latency = 8'(($urandom % 10) + 1);
            read_and_compare(random_addr(64), "random read");
        end
        mem_latency = 8'd2;
    endtask

    initial
    begin
        int unsigned seed;
        seed = 32'h0aef_6af8;
        void'($urandom(seed));
        clk         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        flush       = 1'b0;
        mem_no_ack  = 1'b0;
        mem_latency = 8'd2;
        for (int i = 0; i < 2 ** MEM_BITS; i++)
        begin
            ref_mem[i]       = $urandom;
            mem_i.words[i]   = ref_mem[i];
        end
        for (int s = 0; s < NSETS; s++)
        begin
            shadow[s] = '0;
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        if (!busy)
        begin
            error_count++;
            $display("o_busy is low after reset, so the reset flush did not start");
        end
        while (busy)                        // Reset flush clears every set
        begin
            if (bus.read || bus.write || ack)
            begin
                error_count++;
                $display("[ERROR] %0t bus request or ack raised during the reset flush",
                         $time);
            end
            @(posedge clk);
            #1;
        end
        miss_then_hit();
        conflict_eviction();
        write_through();
        flush_invalidates();
        bus_timeout();
        random_latency_reads();
        $display("Run complete with %0d errors", error_count);
        if (error_count == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/tb_bus_memory.sv */
`timescale 1ns/1ps

module tb_bus_memory
    import cache_pkg::*;
#(
    parameter int WORD_BITS = 10
)
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  bus_req_t   i_bus,
    input  logic [7:0] i_latency,       // Cycles from request to ack with a minimum of 1
    input  logic       i_no_ack,
    output logic       o_bus_ack,
    output word_t      o_bus_data
);

    word_t                words [2 ** WORD_BITS];
    logic [7:0]           wait_q;
    logic [WORD_BITS-1:0] word_idx;
    logic                 active;

    // The word array covers a window at the bottom of the address space
    assign word_idx = i_bus.addr[WORD_BITS+1:2];
    assign active   = (i_bus.read || i_bus.write) && !i_no_ack;

    // ########################################
    // Ack timing and access
    // ########################################

    always @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wait_q     <= '0;
            o_bus_ack  <= 1'b0;
            o_bus_data <= '0;
        end
        else if (o_bus_ack || !active)
        begin
            wait_q    <= '0;
            o_bus_ack <= 1'b0;              // The master drops its request with the ack
        end
        else if (wait_q + 8'd1 >= i_latency)
        begin
            o_bus_ack  <= 1'b1;
            o_bus_data <= words[word_idx];
            if (i_bus.write)
            begin
                for (int l = 0; l < 4; l++)
                begin
                    if (i_bus.sel[l])
                    begin
                        words[word_idx][8*l +: 8] = i_bus.wdata[8*l +: 8];
                    end
                end
            end
        end
        else
        begin
            wait_q <= wait_q + 8'd1;
        end
    end

endmodule
